// File: common/alu_params.svh
`ifndef ALU_PARAMS_SVH
`define ALU_PARAMS_SVH

// operand width of the datapath.
`define ALU_WIDTH 32

// queue entries, also the issuer's starting credits.
`define ALU_QUEUE_DEPTH 4

// result slots the consumer grants after reset.
`define ALU_RESULT_CREDITS 2

`endif

// File: common/alu_pkg.sv
`default_nettype none

package alu_pkg;

	// opcode encodings of the teaching cpu isa.
	typedef enum logic [4:0] {
		OP_ADD  = 5'd3,
		OP_SUB  = 5'd4,
		OP_AND  = 5'd5,
		OP_OR   = 5'd6,
		OP_SHR  = 5'd7,
		OP_SHRA = 5'd8,
		OP_SHL  = 5'd9,
		OP_ROR  = 5'd10,
		OP_ROL  = 5'd11,
		OP_MUL  = 5'd15,
		OP_DIV  = 5'd16,
		OP_NEG  = 5'd17,
		OP_NOT  = 5'd18
	} alu_op_e;

	// alu control, waiting on a multicycle unit.
	typedef enum logic [1:0] {
		ALU_IDLE,
		MUL_WAIT,
		DIV_WAIT
	} alu_state_e;

	// shared by the multiplier and the divider.
	typedef enum logic [1:0] {
		SEQ_IDLE,
		SEQ_RUN,
		SEQ_FIX
	} seq_state_e;

endpackage

`default_nettype wire

// File: design/op_queue.sv
`default_nettype none

`include "alu_params.svh"

module op_queue (
	input  wire                     clk,
	input  wire                     reset,
	input  wire                     push,
	input  wire alu_pkg::alu_op_e   push_opcode,
	input  wire [`ALU_WIDTH-1:0]    push_a,
	input  wire [`ALU_WIDTH-1:0]    push_b,
	input  wire                     pop,
	output logic                    empty,
	output alu_pkg::alu_op_e        head_opcode,
	output logic [`ALU_WIDTH-1:0]   head_a,
	output logic [`ALU_WIDTH-1:0]   head_b,
	output logic                    credit
);
	localparam int DEPTH = `ALU_QUEUE_DEPTH;
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	alu_pkg::alu_op_e        opcode_mem [DEPTH];
	logic [`ALU_WIDTH-1:0]   a_mem [DEPTH];
	logic [`ALU_WIDTH-1:0]   b_mem [DEPTH];
	logic [PTR_W-1:0]        wr_ptr;
	logic [PTR_W-1:0]        rd_ptr;
	logic [CNT_W-1:0]        count;
	logic                    do_pop;

	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		next_ptr = (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign empty = (count == '0);
	assign do_pop = pop && !empty;

	always_ff @(posedge clk) begin
		if (push) begin
			opcode_mem[wr_ptr] <= push_opcode;
			a_mem[wr_ptr] <= push_a;
			b_mem[wr_ptr] <= push_b;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			credit <= 1'b0;
		end else begin
			if (push)
				wr_ptr <= next_ptr(wr_ptr);
			if (do_pop)
				rd_ptr <= next_ptr(rd_ptr);
			case ({push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: ;
			endcase
			credit <= do_pop; // slot freed, hand it back.
		end
	end

	assign head_opcode = opcode_mem[rd_ptr];
	assign head_a = a_mem[rd_ptr];
	assign head_b = b_mem[rd_ptr];

endmodule

`default_nettype wire

// File: alu/alu_simple.sv
`default_nettype none

`include "alu_params.svh"

module alu_simple (
	input  wire alu_pkg::alu_op_e    opcode,
	input  wire [`ALU_WIDTH-1:0]     ra,
	input  wire [`ALU_WIDTH-1:0]     rb,
	output logic [`ALU_WIDTH-1:0]    result
);
	localparam int W = `ALU_WIDTH;
	localparam int SHIFT_W = $clog2(W);

	logic [SHIFT_W-1:0]   shamt;
	logic [2*W-1:0]       ra_twice;
	logic [2*W-1:0]       rot_r;
	logic [2*W-1:0]       rot_l;

	assign shamt = rb[SHIFT_W-1:0]; // upper bits ignored.

	// rotates come from shifting two copies of ra.
	assign ra_twice = {ra, ra};
	assign rot_r = ra_twice >> shamt;
	assign rot_l = ra_twice << shamt;

	always_comb begin
		case (opcode)
			alu_pkg::OP_ADD:
				result = ra + rb;
			alu_pkg::OP_SUB:
				result = ra - rb;
			alu_pkg::OP_AND:
				result = ra & rb;
			alu_pkg::OP_OR:
				result = ra | rb;
			alu_pkg::OP_NEG:
				result = -rb;
			alu_pkg::OP_NOT:
				result = ~rb;
			alu_pkg::OP_SHR:
				result = ra >> shamt;
			alu_pkg::OP_SHL:
				result = ra << shamt;
			alu_pkg::OP_SHRA:
				result = $signed(ra) >>> shamt; // sign fill.
			alu_pkg::OP_ROR:
				result = rot_r[W-1:0];
			alu_pkg::OP_ROL:
				result = rot_l[2*W-1:W];
			default:
				result = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: alu/booth_mul.sv
`default_nettype none

`include "alu_params.svh"

module booth_mul (
	input  wire                       clk,
	input  wire                       reset,
	input  wire                       start,
	input  wire [`ALU_WIDTH-1:0]      multiplicand,
	input  wire [`ALU_WIDTH-1:0]      multiplier,
	output logic                      done,
	output logic [2*`ALU_WIDTH-1:0]   product
);
	localparam int W = `ALU_WIDTH;
	localparam int STEPS = W / 2;
	localparam int CNT_W = $clog2(STEPS);

	alu_pkg::seq_state_e   state;
	logic [CNT_W-1:0]      step;
	logic signed [W+1:0]   mcand; // two guard bits for 2x.
	logic signed [W+1:0]   acc;
	logic [W-1:0]          mplier;
	logic                  q_prev;
	logic signed [W+1:0]   partial;
	logic signed [W+1:0]   sum;

	// radix-4 recoding of two multiplier bits plus the last one shifted out.
	always_comb begin
		case ({mplier[1:0], q_prev})
			3'b001, 3'b010: partial = mcand;
			3'b011:         partial = mcand <<< 1;
			3'b100:         partial = -(mcand <<< 1);
			3'b101, 3'b110: partial = -mcand;
			default:        partial = '0;
		endcase
	end

	assign sum = acc + partial;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= alu_pkg::SEQ_IDLE;
			step <= '0;
		end else begin
			case (state)
				alu_pkg::SEQ_IDLE: begin
					if (start) begin
						state <= alu_pkg::SEQ_RUN;
						step <= '0;
					end
				end
				alu_pkg::SEQ_RUN: begin
					step <= step + 1'b1;
					if (step == CNT_W'(STEPS - 1))
						state <= alu_pkg::SEQ_FIX;
				end
				alu_pkg::SEQ_FIX:
					state <= alu_pkg::SEQ_IDLE;
				default:
					state <= alu_pkg::SEQ_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == alu_pkg::SEQ_IDLE && start) begin
			mcand <= {{2{multiplicand[W-1]}}, multiplicand};
			acc <= '0;
			mplier <= multiplier;
			q_prev <= 1'b0;
		end else if (state == alu_pkg::SEQ_RUN) begin
			acc <= {{2{sum[W+1]}}, sum[W+1:2]}; // arithmetic shift by two.
			mplier <= {sum[1:0], mplier[W-1:2]};
			q_prev <= mplier[1];
		end
	end

	// low half has replaced the multiplier by the fix cycle.
	assign done = (state == alu_pkg::SEQ_FIX);
	assign product = {acc[W-1:0], mplier};

endmodule

`default_nettype wire

// File: alu/div_32_bit.sv
`default_nettype none

`include "alu_params.svh"

module div_32_bit (
	input  wire                     clk,
	input  wire                     reset,
	input  wire                     start,
	input  wire [`ALU_WIDTH-1:0]    dividend,
	input  wire [`ALU_WIDTH-1:0]    divisor,
	output logic                    done,
	output logic [`ALU_WIDTH-1:0]   quotient,
	output logic [`ALU_WIDTH-1:0]   remainder
);
	localparam int W = `ALU_WIDTH;
	localparam int CNT_W = $clog2(W);

	alu_pkg::seq_state_e   state;
	logic [CNT_W-1:0]      step;
	logic [W:0]            rem;
	logic [W-1:0]          quo;
	logic [W-1:0]          dsor;
	logic                  dvd_neg;
	logic                  quo_neg;
	logic                  by_zero;
	logic [W-1:0]          dvd_mag;
	logic [W-1:0]          dsor_mag;
	logic [W:0]            shifted;
	logic [W:0]            trial;
	logic [W:0]            rem_fix;

	assign dvd_mag = dividend[W-1] ? -dividend : dividend;
	assign dsor_mag = divisor[W-1] ? -divisor : divisor;

	// next dividend bit enters from the quotient register.
	assign shifted = {rem[W-1:0], quo[W-1]};
	assign trial = rem[W] ? shifted + {1'b0, dsor} : shifted - {1'b0, dsor};

	assign rem_fix = rem[W] ? rem + {1'b0, dsor} : rem; // restore step.

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= alu_pkg::SEQ_IDLE;
			step <= '0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				alu_pkg::SEQ_IDLE: begin
					if (start) begin
						state <= alu_pkg::SEQ_RUN;
						step <= '0;
					end
				end
				alu_pkg::SEQ_RUN: begin
					step <= step + 1'b1;
					if (step == CNT_W'(W - 1))
						state <= alu_pkg::SEQ_FIX;
				end
				alu_pkg::SEQ_FIX: begin
					state <= alu_pkg::SEQ_IDLE;
					done <= 1'b1;
				end
				default:
					state <= alu_pkg::SEQ_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		case (state)
			alu_pkg::SEQ_IDLE: begin
				if (start) begin
					rem <= '0;
					quo <= dvd_mag;
					dsor <= dsor_mag;
					dvd_neg <= dividend[W-1];
					quo_neg <= dividend[W-1] ^ divisor[W-1];
					by_zero <= (divisor == '0);
				end
			end
			alu_pkg::SEQ_RUN: begin
				rem <= trial;
				quo <= {quo[W-2:0], ~trial[W]};
			end
			alu_pkg::SEQ_FIX: begin
				// truncate toward zero, remainder follows the dividend.
				quotient <= by_zero ? '1 : (quo_neg ? -quo : quo);
				remainder <= dvd_neg ? -rem_fix[W-1:0] : rem_fix[W-1:0];
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// File: alu/alu.sv
`default_nettype none

`include "alu_params.svh"

module alu (
	input  wire                       clk,
	input  wire                       reset,
	input  wire                       start,
	input  wire alu_pkg::alu_op_e     opcode,
	input  wire [`ALU_WIDTH-1:0]      ra,
	input  wire [`ALU_WIDTH-1:0]      rb,
	output logic                      ready,
	output logic                      done,
	output logic [2*`ALU_WIDTH-1:0]   rc
);
	localparam int W = `ALU_WIDTH;

	alu_pkg::alu_state_e   state;
	logic [W-1:0]          simple_result;
	logic                  simple_start;
	logic                  mul_start;
	logic                  div_start;
	logic                  mul_done;
	logic                  div_done;
	logic [2*W-1:0]        product;
	logic [W-1:0]          quotient;
	logic [W-1:0]          remainder;

	assign ready = (state == alu_pkg::ALU_IDLE);

	assign mul_start = start && ready && (opcode == alu_pkg::OP_MUL);
	assign div_start = start && ready && (opcode == alu_pkg::OP_DIV);
	assign simple_start = start && ready && !mul_start && !div_start;

	alu_simple u_alu_simple (
		.opcode (opcode),
		.ra     (ra),
		.rb     (rb),
		.result (simple_result)
	);

	booth_mul u_booth_mul (
		.clk          (clk),
		.reset        (reset),
		.start        (mul_start),
		.multiplicand (ra),
		.multiplier   (rb),
		.done         (mul_done),
		.product      (product)
	);

	div_32_bit u_div_32_bit (
		.clk       (clk),
		.reset     (reset),
		.start     (div_start),
		.dividend  (ra),
		.divisor   (rb),
		.done      (div_done),
		.quotient  (quotient),
		.remainder (remainder)
	);

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= alu_pkg::ALU_IDLE;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				alu_pkg::ALU_IDLE: begin
					if (mul_start)
						state <= alu_pkg::MUL_WAIT;
					else if (div_start)
						state <= alu_pkg::DIV_WAIT;
					else if (simple_start)
						done <= 1'b1; // single cycle op.
				end
				alu_pkg::MUL_WAIT: begin
					if (mul_done) begin
						state <= alu_pkg::ALU_IDLE;
						done <= 1'b1;
					end
				end
				alu_pkg::DIV_WAIT: begin
					if (div_done) begin
						state <= alu_pkg::ALU_IDLE;
						done <= 1'b1;
					end
				end
				default: state <= alu_pkg::ALU_IDLE;
			endcase
		end
	end

	// result register.
	always_ff @(posedge clk) begin
		if (simple_start)
			rc <= {{W{1'b0}}, simple_result};
		else if (state == alu_pkg::MUL_WAIT && mul_done)
			rc <= product;
		else if (state == alu_pkg::DIV_WAIT && div_done)
			rc <= {remainder, quotient}; // remainder on top.
	end

endmodule

`default_nettype wire

// File: design/alu_exec.sv
`default_nettype none

`include "alu_params.svh"

module alu_exec (
	input  wire                       clk,
	input  wire                       reset,
	input  wire                       req_valid,
	input  wire alu_pkg::alu_op_e     req_opcode,
	input  wire [`ALU_WIDTH-1:0]      req_a,
	input  wire [`ALU_WIDTH-1:0]      req_b,
	output logic                      req_credit,
	output logic                      res_valid,
	output logic [2*`ALU_WIDTH-1:0]   res_data,
	input  wire                       res_credit
);
	localparam int CREDIT_W = $clog2(`ALU_RESULT_CREDITS + 1);

	alu_pkg::alu_op_e        head_opcode;
	logic [`ALU_WIDTH-1:0]   head_a;
	logic [`ALU_WIDTH-1:0]   head_b;
	logic                    q_empty;
	logic                    alu_ready;
	logic                    issue;
	logic [CREDIT_W-1:0]     credits;

	op_queue u_op_queue (
		.clk         (clk),
		.reset       (reset),
		.push        (req_valid),
		.push_opcode (req_opcode),
		.push_a      (req_a),
		.push_b      (req_b),
		.pop         (issue),
		.empty       (q_empty),
		.head_opcode (head_opcode),
		.head_a      (head_a),
		.head_b      (head_b),
		.credit      (req_credit)
	);

	// each issue reserves one result slot.
	assign issue = !q_empty && (credits != '0) && alu_ready;

	always_ff @(posedge clk) begin
		if (reset) begin
			credits <= CREDIT_W'(`ALU_RESULT_CREDITS);
		end else begin
			case ({res_credit, issue})
				2'b10: credits <= credits + 1'b1;
				2'b01: credits <= credits - 1'b1;
				default: ; // both or neither.
			endcase
		end
	end

	alu u_alu (
		.clk    (clk),
		.reset  (reset),
		.start  (issue),
		.opcode (head_opcode),
		.ra     (head_a),
		.rb     (head_b),
		.ready  (alu_ready),
		.done   (res_valid),
		.rc     (res_data)
	);

endmodule

`default_nettype wire

// File: sim/tb_alu_exec.sv
`default_nettype none

`include "alu_params.svh"

module tb_alu_exec;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int W = `ALU_WIDTH;
	localparam int RANDOM_ROWS = 30;
	localparam int WITHHOLD_AT = 40;
	localparam int WITHHOLD_CYCLES = 120;
	localparam int WAIT_LIMIT = 2000;

	logic                 clk;
	logic                 reset;
	logic                 req_valid;
	alu_pkg::alu_op_e     req_opcode;
	logic [W-1:0]         req_a;
	logic [W-1:0]         req_b;
	logic                 req_credit;
	logic                 res_valid;
	logic [2*W-1:0]       res_data;
	logic                 res_credit;

	alu_pkg::alu_op_e     tab_op [$];
	logic [W-1:0]         tab_a [$];
	logic [W-1:0]         tab_b [$];
	logic [2*W-1:0]       tab_exp [$];
	logic [2*W-1:0]       exp_q [$];
	int                   exp_row [$];

	int     sent = 0;
	int     received = 0;
	int     returned = 0;
	int     req_credits_seen = 0;
	int     withhold_left = 0;
	int     release_wait = 0;

	alu_exec u_alu_exec (
		.clk        (clk),
		.reset      (reset),
		.req_valid  (req_valid),
		.req_opcode (req_opcode),
		.req_a      (req_a),
		.req_b      (req_b),
		.req_credit (req_credit),
		.res_valid  (res_valid),
		.res_data   (res_data),
		.res_credit (res_credit)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("Test failures found");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_value(input logic [2*W-1:0] actual, input logic [2*W-1:0] expected,
			input string what);
		if (actual !== expected)
			fail_run($sformatf("MISMATCH at %0d ns: %s, got %h, expected %h",
				$time, what, actual, expected));
	endtask

	// expected result straight from the opcode rules.
	function automatic logic [2*W-1:0] model_result(input alu_pkg::alu_op_e op,
			input logic [W-1:0] a, input logic [W-1:0] b);
		logic [4:0]   sh;
		logic [W-1:0] lo;
		longint       a_s;
		longint       b_s;
		longint       a_mag;
		longint       b_mag;
		longint       q;
		longint       r;
		sh = b[4:0];
		a_s = $signed(a);
		b_s = $signed(b);
		lo = '0;
		case (op)
			alu_pkg::OP_ADD:  lo = a + b;
			alu_pkg::OP_SUB:  lo = a - b;
			alu_pkg::OP_AND:  lo = a & b;
			alu_pkg::OP_OR:   lo = a | b;
			alu_pkg::OP_NEG:  lo = -b;
			alu_pkg::OP_NOT:  lo = ~b;
			alu_pkg::OP_SHR:  lo = a >> sh;
			alu_pkg::OP_SHL:  lo = a << sh;
			alu_pkg::OP_SHRA: lo = (a >> sh) | ({W{a[W-1]}} << (W - sh));
			alu_pkg::OP_ROR:  lo = (a >> sh) | (a << (W - sh));
			alu_pkg::OP_ROL:  lo = (a << sh) | (a >> (W - sh));
			alu_pkg::OP_MUL:  return a_s * b_s;
			alu_pkg::OP_DIV: begin
				if (b == '0)
					return {a, {W{1'b1}}};
				a_mag = (a_s < 0) ? -a_s : a_s;
				b_mag = (b_s < 0) ? -b_s : b_s;
				q = a_mag / b_mag;
				r = a_mag % b_mag;
				if ((a_s < 0) != (b_s < 0))
					q = -q;
				if (a_s < 0)
					r = -r; // remainder follows the dividend.
				return {r[W-1:0], q[W-1:0]};
			end
			default:          lo = '0;
		endcase
		return {{W{1'b0}}, lo};
	endfunction

	task automatic add_row(input alu_pkg::alu_op_e op, input logic [W-1:0] a,
			input logic [W-1:0] b, input logic [2*W-1:0] expected);
		tab_op.push_back(op);
		tab_a.push_back(a);
		tab_b.push_back(b);
		tab_exp.push_back(expected);
	endtask

	task automatic add_random_rows(input int n);
		alu_pkg::alu_op_e op_list [13] = '{alu_pkg::OP_ADD, alu_pkg::OP_SUB, alu_pkg::OP_AND,
			alu_pkg::OP_OR, alu_pkg::OP_SHR, alu_pkg::OP_SHRA, alu_pkg::OP_SHL,
			alu_pkg::OP_ROR, alu_pkg::OP_ROL, alu_pkg::OP_MUL, alu_pkg::OP_DIV,
			alu_pkg::OP_NEG, alu_pkg::OP_NOT};
		alu_pkg::alu_op_e op;
		logic [W-1:0] a;
		logic [W-1:0] b;
		for (int i = 0; i < n; i++) begin
			op = op_list[$urandom_range(12, 0)];
			a = $urandom();
			b = $urandom();
			if (i % 3 == 0)
				a = a | 32'h8000_0000; // force some negative operands.
			add_row(op, a, b, model_result(op, a, b));
		end
	endtask

	task automatic build_table();
		add_row(alu_pkg::OP_ADD, 32'hffff_ffff, 32'h1, 64'h0);
		add_row(alu_pkg::OP_ADD, 32'h1234_5678, 32'h1111_1111, 64'h2345_6789);
		add_row(alu_pkg::OP_SUB, 32'h0, 32'h1, 64'hffff_ffff);
		add_row(alu_pkg::OP_SUB, 32'd100, 32'd58, 64'h2a);
		add_row(alu_pkg::OP_AND, 32'hf0f0_f0f0, 32'hff00_ff00, 64'hf000_f000);
		add_row(alu_pkg::OP_OR, 32'hf0f0_f0f0, 32'h0f00_000f, 64'hfff0_f0ff);
		add_row(alu_pkg::OP_NEG, 32'h1234, 32'h5, 64'hffff_fffb);
		add_row(alu_pkg::OP_NOT, 32'h0, 32'h0f0f_0f0f, 64'hf0f0_f0f0);
		add_row(alu_pkg::OP_SHR, 32'h8000_0000, 32'd4, 64'h0800_0000);
		add_row(alu_pkg::OP_SHR, 32'hf000_0000, 32'h24, 64'h0f00_0000); // only 4:0 count.
		add_row(alu_pkg::OP_SHL, 32'h1, 32'd31, 64'h8000_0000);
		add_row(alu_pkg::OP_SHL, 32'h1, 32'd32, 64'h1);
		add_row(alu_pkg::OP_SHRA, 32'h8000_0000, 32'd4, 64'hf800_0000);
		add_row(alu_pkg::OP_SHRA, 32'h7000_0000, 32'd4, 64'h0700_0000);
		add_row(alu_pkg::OP_ROR, 32'h1234_5678, 32'd8, 64'h7812_3456);
		add_row(alu_pkg::OP_ROR, 32'h1234_5678, 32'd0, 64'h1234_5678);
		add_row(alu_pkg::OP_ROL, 32'h8000_0001, 32'd1, 64'h3);
		add_row(alu_pkg::OP_ROL, 32'h1234_5678, 32'h20, 64'h1234_5678);
		add_row(alu_pkg::OP_MUL, 32'd3, 32'hffff_fffc, 64'hffff_ffff_ffff_fff4);
		add_row(alu_pkg::OP_MUL, 32'h8000_0000, 32'h8000_0000, 64'h4000_0000_0000_0000);
		add_row(alu_pkg::OP_MUL, 32'h7fff_ffff, 32'h7fff_ffff, 64'h3fff_ffff_0000_0001);
		add_row(alu_pkg::OP_MUL, 32'hffff_ffff, 32'hffff_ffff, 64'h1);
		add_row(alu_pkg::OP_MUL, 32'h8000_0000, 32'h7fff_ffff, 64'hc000_0000_8000_0000);
		add_row(alu_pkg::OP_DIV, 32'd7, 32'd2, 64'h0000_0001_0000_0003);
		add_row(alu_pkg::OP_DIV, 32'hffff_fff9, 32'd2, 64'hffff_ffff_ffff_fffd);
		add_row(alu_pkg::OP_DIV, 32'd7, 32'hffff_fffe, 64'h0000_0001_ffff_fffd);
		add_row(alu_pkg::OP_DIV, 32'hffff_fff9, 32'hffff_fffe, 64'hffff_ffff_0000_0003);
		add_row(alu_pkg::OP_DIV, 32'h8000_0000, 32'hffff_ffff, 64'h0000_0000_8000_0000);
		add_row(alu_pkg::OP_DIV, 32'd1234, 32'd0, 64'h0000_04d2_ffff_ffff);
		add_row(alu_pkg::OP_DIV, 32'hffff_fffb, 32'd0, 64'hffff_fffb_ffff_ffff);
		add_row(alu_pkg::alu_op_e'(5'd0), 32'h1234, 32'h5678, 64'h0);
		add_row(alu_pkg::alu_op_e'(5'd31), 32'hffff_ffff, 32'hffff_ffff, 64'h0);
		// simple ops right behind the slow ones.
		add_row(alu_pkg::OP_MUL, 32'd100, 32'd200, 64'h4e20);
		add_row(alu_pkg::OP_ADD, 32'd1, 32'd1, 64'h2);
		add_row(alu_pkg::OP_DIV, 32'd100, 32'd7, 64'h0000_0002_0000_000e);
		add_row(alu_pkg::OP_NOT, 32'h0, 32'h0, 64'hffff_ffff);
		add_random_rows(RANDOM_ROWS);
	endtask

	// sample outputs away from the rising edge.
	always @(negedge clk) begin : monitor
		logic [2*W-1:0] expected;
		int row;
		if (!reset && req_credit)
			req_credits_seen++;
		if (!reset && res_valid) begin
			if (exp_q.size() == 0)
				fail_run("a result arrived while no operation was outstanding");
			expected = exp_q.pop_front();
			row = exp_row.pop_front();
			check_value(res_data, expected, $sformatf("result of row %0d", row));
			received++;
			if (received - returned > `ALU_RESULT_CREDITS)
				fail_run($sformatf("consumer holds %0d results but granted only %0d credits",
					received - returned, `ALU_RESULT_CREDITS));
		end
	end

	// consumer hands slots back after a random delay.
	always @(posedge clk) begin
		#1;
		res_credit = 1'b0;
		if (withhold_left > 0) begin
			withhold_left--;
			if (withhold_left == 0 && received - returned != `ALU_RESULT_CREDITS)
				fail_run($sformatf("credits were withheld yet only %0d results were held",
					received - returned));
		end else if (received > returned) begin
			if (release_wait == 0) begin
				res_credit = 1'b1;
				returned++;
				release_wait = $urandom_range(20, 0);
			end else begin
				release_wait--;
			end
		end
	end

	initial begin
		int stall;
		reset = 1'b1;
		req_valid = 1'b0;
		req_opcode = alu_pkg::OP_ADD;
		req_a = '0;
		req_b = '0;
		res_credit = 1'b0;
		void'($urandom(32'hca49_7d23));
		build_table();

		repeat (4) @(posedge clk);
		#1;
		reset = 1'b0;

		// quiet outputs before any traffic.
		repeat (5) begin
			@(negedge clk);
			check_value(64'(res_valid), 64'h0, "res_valid before traffic");
			check_value(64'(req_credit), 64'h0, "req_credit before traffic");
		end
		@(posedge clk);
		#1;

		for (int row = 0; row < tab_op.size(); row++) begin
			stall = 0;
			while (sent - req_credits_seen >= `ALU_QUEUE_DEPTH) begin
				if (stall == WAIT_LIMIT)
					fail_run("issuer waited too long for a queue credit");
				stall++;
				@(posedge clk);
				#1;
				req_valid = 1'b0;
			end
			req_valid = 1'b1;
			req_opcode = tab_op[row];
			req_a = tab_a[row];
			req_b = tab_b[row];
			exp_q.push_back(tab_exp[row]);
			exp_row.push_back(row);
			sent++;
			if (row == WITHHOLD_AT) begin
				@(negedge clk);
				withhold_left = WITHHOLD_CYCLES;
			end
			@(posedge clk);
			#1;
			req_valid = 1'b0;
		end

		stall = 0;
		while (received < tab_op.size()) begin
			@(negedge clk);
			stall++;
			if (stall > WAIT_LIMIT)
				fail_run("results stopped arriving before every operation completed");
		end
		stall = 0;
		while (returned < received) begin
			@(negedge clk);
			stall++;
			if (stall > WAIT_LIMIT)
				fail_run("consumer never returned all of its result credits");
		end
		repeat (30) @(negedge clk);
		check_value(64'(req_credits_seen), 64'(sent), "req_credit pulses against operations sent");

		$display("All tests passed!");
		$finish;
	end

endmodule

`default_nettype wire

// File: flist.f
+incdir+common
common/alu_pkg.sv
design/op_queue.sv
alu/alu_simple.sv
alu/booth_mul.sv
alu/div_32_bit.sv
alu/alu.sv
design/alu_exec.sv
sim/tb_alu_exec.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the alu_exec testbench with verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f flist.f --top-module tb_alu_exec \
	|| { echo "verilator build failed"; exit 1; }

output=$(./obj_dir/Vtb_alu_exec)
echo "$output"

echo "$output" | grep -q "All tests passed!" \
	&& echo "simulation PASSED" \
	|| { echo "simulation FAILED"; exit 1; }
